// File: rtl/routerArb_consts.svh
`ifndef ROUTERARB_CONSTS_SVH
`define ROUTERARB_CONSTS_SVH

// the five input ports are Local, North, East, West and South.
`define ARB_PORTS 5

// flit id and packet length widths seen at each input head.
`define FLIT_ID_WIDTH 3
`define LEN_WIDTH 12

// a head flit carries this id and brings a new packet length.
`define FLIT_HEAD 3'd1

// width of the flit payload forwarded to the output.
`define DATA_WIDTH 32

`endif

// File: rtl/routerArbPkg.sv
`include "routerArb_consts.svh"

package routerArbPkg;

  // ==============================
  // per-port head information
  // ==============================

  // flit id at the head of an input port.
  typedef logic [`FLIT_ID_WIDTH-1:0] flitIdT;

  // packet length, also used as the timer limit and count.
  typedef logic [`LEN_WIDTH-1:0] lenT;

  // ==============================
  // arbitration and data
  // ==============================

  // one-hot grant, bit 0 is Local, then North, East, West, South.
  // all zero means the arbiter is idle.
  typedef logic [`ARB_PORTS-1:0] grantT;

  // flit payload carried through the output multiplexer.
  typedef logic [`DATA_WIDTH-1:0] flitT;

endpackage

// File: rtl/portTimer.sv
`timescale 1ns/1ps
`include "routerArb_consts.svh"

module portTimer (
  input  logic                 clk,
  input  logic                 rst,
  input  routerArbPkg::flitIdT flitId,
  input  routerArbPkg::lenT    length,
  input  logic                 run,
  output logic                 timesUp
);

  routerArbPkg::lenT limit;
  routerArbPkg::lenT count;

  // the limit follows the length of the latest head flit.
  // the count only advances while this port holds the grant.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == `FLIT_HEAD)
      begin
        limit <= length;
      end
      if (run)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  // a holding port sees this on its last granted cycle.
  assign timesUp = (count == limit);

endmodule

// File: rtl/arbiterFsm.sv
`timescale 1ns/1ps
`include "routerArb_consts.svh"

module arbiterFsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                lReq,
  input  logic                nReq,
  input  logic                eReq,
  input  logic                wReq,
  input  logic                sReq,
  input  logic                lTimesUp,
  input  logic                nTimesUp,
  input  logic                eTimesUp,
  input  logic                wTimesUp,
  input  logic                sTimesUp,
  output logic                lRun,
  output logic                nRun,
  output logic                eRun,
  output logic                wRun,
  output logic                sRun,
  output routerArbPkg::grantT grant
);

  // ==============================
  // state encoding
  // ==============================

  // one-hot per port, idle is all zero so the state doubles as the grant.
  localparam routerArbPkg::grantT stIdle  = 5'b00000;
  localparam routerArbPkg::grantT stLocal = 5'b00001;
  localparam routerArbPkg::grantT stNorth = 5'b00010;
  localparam routerArbPkg::grantT stEast  = 5'b00100;
  localparam routerArbPkg::grantT stWest  = 5'b01000;
  localparam routerArbPkg::grantT stSouth = 5'b10000;

  routerArbPkg::grantT state;
  routerArbPkg::grantT nextState;

  logic [`ARB_PORTS-1:0] reqVec;
  logic [`ARB_PORTS-1:0] timesUpVec;
  logic [`ARB_PORTS-1:0] runVec;

  assign reqVec     = {sReq, wReq, eReq, nReq, lReq};
  assign timesUpVec = {sTimesUp, wTimesUp, eTimesUp, nTimesUp, lTimesUp};

  // returns the first requesting port when scanning from port first onwards,
  // wrapping around so that the port just before first is tried last.
  function automatic routerArbPkg::grantT pickFrom(
    input logic [`ARB_PORTS-1:0] reqs,
    input int                    first
  );
    routerArbPkg::grantT pick;
    int                  idx;
    pick = '0;
    // scan backwards so the earliest port in the rotation is written last.
    for (int i = `ARB_PORTS - 1; i >= 0; i--)
    begin
      idx = (first + i) % `ARB_PORTS;
      if (reqs[idx])
      begin
        pick      = '0;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  // ==============================
  // next state and timer run
  // ==============================

  always_comb
  begin
    runVec    = '0;
    nextState = stIdle;
    case (state)
      stIdle:
      begin
        nextState = pickFrom(reqVec, 0);
      end
      stLocal:
      begin
        if (reqVec[0] && !timesUpVec[0])
        begin
          runVec[0] = 1'b1;
          nextState = stLocal;
        end
        else
        begin
          nextState = pickFrom(reqVec, 1);
        end
      end
      stNorth:
      begin
        if (reqVec[1] && !timesUpVec[1])
        begin
          runVec[1] = 1'b1;
          nextState = stNorth;
        end
        else
        begin
          nextState = pickFrom(reqVec, 2);
        end
      end
      stEast:
      begin
        if (reqVec[2] && !timesUpVec[2])
        begin
          runVec[2] = 1'b1;
          nextState = stEast;
        end
        else
        begin
          nextState = pickFrom(reqVec, 3);
        end
      end
      stWest:
      begin
        if (reqVec[3] && !timesUpVec[3])
        begin
          runVec[3] = 1'b1;
          nextState = stWest;
        end
        else
        begin
          nextState = pickFrom(reqVec, 4);
        end
      end
      stSouth:
      begin
        if (reqVec[4] && !timesUpVec[4])
        begin
          runVec[4] = 1'b1;
          nextState = stSouth;
        end
        else
        begin
          nextState = pickFrom(reqVec, 0);
        end
      end
      default:
      begin
        nextState = stIdle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= stIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  assign {sRun, wRun, eRun, nRun, lRun} = runVec;
  assign grant = state;

endmodule

// File: rtl/outputMux.sv
`timescale 1ns/1ps

module outputMux #(
  parameter type payloadT = logic
) (
  input  routerArbPkg::grantT grant,
  input  logic                lReq,
  input  logic                nReq,
  input  logic                eReq,
  input  logic                wReq,
  input  logic                sReq,
  input  payloadT             lFlit,
  input  payloadT             nFlit,
  input  payloadT             eFlit,
  input  payloadT             wFlit,
  input  payloadT             sFlit,
  output payloadT             outFlit,
  output logic                outValid
);

  localparam int PayloadWidth = $bits(payloadT);

  logic [PayloadWidth-1:0] selBits;

  // the grant is one-hot, so an AND-OR picks exactly one port.
  // an idle grant leaves every term masked and the output at zero.
  assign selBits = ({PayloadWidth{grant[0]}} & PayloadWidth'(lFlit))
                 | ({PayloadWidth{grant[1]}} & PayloadWidth'(nFlit))
                 | ({PayloadWidth{grant[2]}} & PayloadWidth'(eFlit))
                 | ({PayloadWidth{grant[3]}} & PayloadWidth'(wFlit))
                 | ({PayloadWidth{grant[4]}} & PayloadWidth'(sFlit));

  assign outFlit = payloadT'(selBits);

  // valid follows the request of whichever port holds the grant.
  assign outValid = |(grant & {sReq, wReq, eReq, nReq, lReq});

endmodule

// File: rtl/outputArbiter.sv
`timescale 1ns/1ps

module outputArbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lReq,
  input  logic                 nReq,
  input  logic                 eReq,
  input  logic                 wReq,
  input  logic                 sReq,
  input  routerArbPkg::flitIdT lFlitId,
  input  routerArbPkg::flitIdT nFlitId,
  input  routerArbPkg::flitIdT eFlitId,
  input  routerArbPkg::flitIdT wFlitId,
  input  routerArbPkg::flitIdT sFlitId,
  input  routerArbPkg::lenT    lLength,
  input  routerArbPkg::lenT    nLength,
  input  routerArbPkg::lenT    eLength,
  input  routerArbPkg::lenT    wLength,
  input  routerArbPkg::lenT    sLength,
  input  routerArbPkg::flitT   lFlit,
  input  routerArbPkg::flitT   nFlit,
  input  routerArbPkg::flitT   eFlit,
  input  routerArbPkg::flitT   wFlit,
  input  routerArbPkg::flitT   sFlit,
  output routerArbPkg::grantT  grant,
  output routerArbPkg::flitT   outFlit,
  output logic                 outValid
);

  logic lRun, nRun, eRun, wRun, sRun;
  logic lTimesUp, nTimesUp, eTimesUp, wTimesUp, sTimesUp;

  // ==============================
  // per-port hold timers
  // ==============================

  portTimer lTimer (.clk, .rst, .flitId(lFlitId), .length(lLength), .run(lRun),
                    .timesUp(lTimesUp));
  portTimer nTimer (.clk, .rst, .flitId(nFlitId), .length(nLength), .run(nRun),
                    .timesUp(nTimesUp));
  portTimer eTimer (.clk, .rst, .flitId(eFlitId), .length(eLength), .run(eRun),
                    .timesUp(eTimesUp));
  portTimer wTimer (.clk, .rst, .flitId(wFlitId), .length(wLength), .run(wRun),
                    .timesUp(wTimesUp));
  portTimer sTimer (.clk, .rst, .flitId(sFlitId), .length(sLength), .run(sRun),
                    .timesUp(sTimesUp));

  // ==============================
  // grant and output path
  // ==============================

  arbiterFsm fsm (
    .clk, .rst,
    .lReq, .nReq, .eReq, .wReq, .sReq,
    .lTimesUp, .nTimesUp, .eTimesUp, .wTimesUp, .sTimesUp,
    .lRun, .nRun, .eRun, .wRun, .sRun,
    .grant
  );

  outputMux #(
    .payloadT(routerArbPkg::flitT)
  ) mux (
    .grant,
    .lReq, .nReq, .eReq, .wReq, .sReq,
    .lFlit, .nFlit, .eFlit, .wFlit, .sFlit,
    .outFlit,
    .outValid
  );

endmodule

// File: sim/outputArbiter_assertions.sv
`timescale 1ns/1ps

module outputArbiterAssertions (
  input logic                clk,
  input logic                rst,
  input routerArbPkg::grantT grant,
  input logic                outValid
);

  // at most one port drives the output at a time.
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant %b has more than one port set", grant);

  // a valid flit needs a port that holds the grant.
  validNeedsGrant: assert property (@(posedge clk) disable iff (rst) outValid |-> grant != '0)
    else $error("outValid is high while the arbiter is idle");

  // reset brings the arbiter to idle on the next edge.
  idleInReset: assert property (@(posedge clk) rst |=> grant == '0)
    else $error("grant %b did not clear during reset", grant);

endmodule

bind outputArbiter outputArbiterAssertions asrt (.clk, .rst, .grant, .outValid);

// File: sim/arbChecker.sv
`timescale 1ns/1ps

module arbChecker (
  input logic                clk,
  input logic                rst,
  input routerArbPkg::grantT dutGrant,
  input routerArbPkg::grantT expGrant,
  input routerArbPkg::flitT  dutFlit,
  input routerArbPkg::flitT  expFlit,
  input logic                dutValid,
  input logic                expValid
);

  int errors = 0;
  int testErrors = 0;
  int testsRun = 0;
  int testsFailed = 0;

  task automatic valueError(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    $display("[ERROR] %s expected %h actual %h at %0t", name, expVal, actVal, $time);
    errors++;
    testErrors++;
  endtask

  task automatic noteFailure(input string what);
    $display("error at %0t: %s", $time, what);
    errors++;
    testErrors++;
  endtask

  // both the DUT and the model update with nonblocking assignments.
  // the values seen here are the ones from before this edge
  always @(posedge clk)
  begin
    if (dutGrant !== expGrant)
      valueError("grant", 32'(expGrant), 32'(dutGrant));
    if (!rst && dutFlit !== expFlit)
      valueError("outFlit", expFlit, dutFlit);
    if (!rst && dutValid !== expValid)
      valueError("outValid", 32'(expValid), 32'(dutValid));
  end

  task automatic finishTest(input string name);
    testsRun++;
    if (testErrors != 0)
      testsFailed++;
    $display("test %s: %s, %0d errors", name, (testErrors == 0) ? "ok" : "failed", testErrors);
    testErrors = 0;
  endtask

  task automatic printCounts();
    $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
  endtask

endmodule

// File: sim/outputArbiterTb.sv
`timescale 1ns/1ps
`include "routerArb_consts.svh"

module outputArbiterTb;

  logic clk;
  logic rst;
  logic [`ARB_PORTS-1:0] req;
  routerArbPkg::flitIdT flitId [`ARB_PORTS];
  routerArbPkg::lenT length [`ARB_PORTS];
  routerArbPkg::flitT flit [`ARB_PORTS];
  routerArbPkg::grantT grant;
  routerArbPkg::flitT outFlit;
  logic outValid;

  // reference model state and its expected outputs.
  routerArbPkg::grantT mGrant;
  routerArbPkg::lenT mLimit [`ARB_PORTS];
  routerArbPkg::lenT mCount [`ARB_PORTS];
  logic [`ARB_PORTS-1:0] mTimesUp;
  routerArbPkg::flitT expFlit;
  logic expValid;

  outputArbiter uut (
    .clk, .rst, .grant, .outFlit, .outValid,
    .lReq(req[0]), .nReq(req[1]), .eReq(req[2]), .wReq(req[3]), .sReq(req[4]),
    .lFlitId(flitId[0]), .nFlitId(flitId[1]), .eFlitId(flitId[2]), .wFlitId(flitId[3]),
    .sFlitId(flitId[4]), .lLength(length[0]), .nLength(length[1]), .eLength(length[2]),
    .wLength(length[3]), .sLength(length[4]), .lFlit(flit[0]), .nFlit(flit[1]),
    .eFlit(flit[2]), .wFlit(flit[3]), .sFlit(flit[4])
  );

  arbChecker chk (
    .clk, .rst, .dutGrant(grant), .expGrant(mGrant), .dutFlit(outFlit), .expFlit,
    .dutValid(outValid), .expValid
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==============================
  // reference model
  // ==============================

  // the holder keeps the grant while it requests and has time left.
  // otherwise the scan starts after the holder and reaches the holder itself last.
  function automatic routerArbPkg::grantT nextGrant(input routerArbPkg::grantT g,
    input logic [`ARB_PORTS-1:0] r, input logic [`ARB_PORTS-1:0] up);
    routerArbPkg::grantT res;
    int holder;
    res = '0;
    holder = -1;
    for (int p = 0; p < `ARB_PORTS; p++)
      if (g[p]) holder = p;
    if (holder >= 0 && r[holder] && !up[holder])
      return g;
    for (int k = 1; k <= `ARB_PORTS; k++)
      if (res == '0 && r[(holder + k) % `ARB_PORTS])
        res[(holder + k) % `ARB_PORTS] = 1'b1;
    return res;
  endfunction

  always_comb
  begin
    expFlit = '0;
    for (int p = 0; p < `ARB_PORTS; p++)
    begin
      mTimesUp[p] = (mCount[p] == mLimit[p]);
      expFlit = expFlit | (mGrant[p] ? flit[p] : '0);
    end
    expValid = |(mGrant & req);
  end

  always @(posedge clk)
  begin
    mGrant <= rst ? '0 : nextGrant(mGrant, req, mTimesUp);
    for (int p = 0; p < `ARB_PORTS; p++)
    begin
      mLimit[p] <= rst ? '0 : ((flitId[p] == `FLIT_HEAD) ? length[p] : mLimit[p]);
      mCount[p] <= (!rst && mGrant[p] && req[p] && !mTimesUp[p]) ? mCount[p] + 1'b1 : '0;
    end
  end

  // ==============================
  // stimulus helpers
  // ==============================

  // a head flit sets the hold length of its port.
  task automatic startPacket(input int p, input int len);
    flitId[p] = `FLIT_HEAD;
    length[p] = routerArbPkg::lenT'(len);
    req[p] = 1'b1;
  endtask

  task automatic newFlits();
    for (int p = 0; p < `ARB_PORTS; p++)
      flit[p] = $urandom;
  endtask

  task automatic waitGrant(input routerArbPkg::grantT want, input int limit);
    int n;
    n = 0;
    while (grant !== want && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    if (grant !== want)
      chk.noteFailure($sformatf("grant never became %b within %0d cycles", want, limit));
  endtask

  task automatic releaseAll();
    req = '0;
    for (int p = 0; p < `ARB_PORTS; p++)
      flitId[p] = '0;
    waitGrant('0, 8);
  endtask

  initial
  begin
    int p;
    int len;
    int held;
    routerArbPkg::grantT want;
    logic [`ARB_PORTS-1:0] others;
    void'($urandom(32'h875e));
    rst = 1'b1;
    req = '0;
    for (int i = 0; i < `ARB_PORTS; i++)
    begin
      flitId[i] = '0;
      length[i] = '0;
      flit[i] = '0;
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;
    repeat (6) @(negedge clk);
    chk.finishTest("reset and idle");

    for (int round = 0; round < 6; round++)
    begin
      newFlits();
      req = `ARB_PORTS'($urandom) | (`ARB_PORTS'(1) << ($urandom % `ARB_PORTS));
      want = req & (~req + 1'b1);
      waitGrant(want, 4);
      releaseAll();
    end
    chk.finishTest("idle priority");

    // the next port in the rotation waits while the holder runs out its timer.
    for (int round = 0; round < 5; round++)
    begin
      p = $urandom % `ARB_PORTS;
      len = 2 + $urandom % 8;
      startPacket(p, len);
      waitGrant(routerArbPkg::grantT'(1 << p), 4);
      flitId[p] = '0;
      req[(p + 1) % `ARB_PORTS] = 1'b1;
      held = 0;
      while (grant == (1 << p) && held < 64)
      begin
        held++;
        @(negedge clk);
      end
      if (held != len + 1)
        chk.valueError("holdCycles", 32'(len + 1), 32'(held));
      if (grant !== (1 << ((p + 1) % `ARB_PORTS)))
        chk.valueError("grant", 32'(1 << ((p + 1) % `ARB_PORTS)), 32'(grant));
      releaseAll();
    end
    chk.finishTest("timer bound");

    for (int round = 0; round < 6; round++)
    begin
      p = $urandom % `ARB_PORTS;
      startPacket(p, 200);
      waitGrant(routerArbPkg::grantT'(1 << p), 4);
      flitId[p] = '0;
      others = `ARB_PORTS'($urandom) & ~(`ARB_PORTS'(1) << p);
      want = nextGrant(routerArbPkg::grantT'(1 << p), others, '0);
      req = others;
      waitGrant(want, 4);
      releaseAll();
    end
    chk.finishTest("early release");

    p = $urandom % `ARB_PORTS;
    startPacket(p, 40);
    waitGrant(routerArbPkg::grantT'(1 << p), 4);
    flitId[p] = '0;
    repeat (8)
    begin
      newFlits();
      @(negedge clk);
      if (outFlit !== flit[p])
        chk.valueError("outFlit", flit[p], outFlit);
      if (outValid !== 1'b1)
        chk.valueError("outValid", 32'h1, 32'(outValid));
    end
    releaseAll();
    chk.finishTest("data path");

    for (int cyc = 0; cyc < 2000; cyc++)
    begin
      for (int i = 0; i < `ARB_PORTS; i++)
      begin
        req[i] = ($urandom % 4) != 0;
        flitId[i] = ($urandom % 4 == 0) ? `FLIT_HEAD : routerArbPkg::flitIdT'($urandom);
        length[i] = routerArbPkg::lenT'($urandom % 12);
        flit[i] = $urandom;
      end
      @(negedge clk);
    end
    chk.finishTest("random run");

    chk.printCounts();
    if (chk.errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: all.f
+incdir+rtl
rtl/routerArbPkg.sv
rtl/portTimer.sv
rtl/arbiterFsm.sv
rtl/outputMux.sv
rtl/outputArbiter.sv
sim/outputArbiter_assertions.sv
sim/arbChecker.sv
sim/outputArbiterTb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in its output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module outputArbiterTb \
  -Wno-fatal -f all.f -o outputArbiterSim &&
  ./obj_dir/outputArbiterSim | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null &&
  echo "simulation passed" || { echo "simulation failed"; exit 1; }
